// ==== opl3_ctrl_pkg.sv ====
// operator control package
// counts, widths, types and register map shared by the FM operator control block
package opl3_ctrl_pkg;

    localparam int NUM_BANKS        = 2;
    localparam int NUM_OPS_PER_BANK = 18;
    localparam int NUM_CHANNELS     = 9;   // channels per bank
    localparam int PIPELINE_DELAY   = 6;
    localparam int OP_OUT_WIDTH     = 13;

    // operator registers span 0x00-0x15 with two-offset gaps between groups
    localparam int OP_REG_DEPTH = 'h16;
    localparam int KON_BIT      = 5;   // key-on position in 0xB0-0xB8 data
    localparam int CNT_BIT      = 0;   // connection position in 0xC0-0xC8 data

    typedef logic [0:0] bank_num_t;
    typedef logic [4:0] op_num_t;
    typedef logic [3:0] chan_num_t;
    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;
    typedef logic [3:0] mult_t;
    typedef logic [5:0] tl_t;
    typedef logic signed [OP_OUT_WIDTH-1:0] op_out_t;
    typedef logic [5:0] conn_sel_t;   // bits 0-2 bank 0, bits 3-5 bank 1

    typedef enum logic {
        SCHED_IDLE,
        SCHED_SWEEP
    } sched_state_t;

    // register base addresses
    localparam reg_addr_t MULT_BASE = 8'h20;
    localparam reg_addr_t TL_BASE   = 8'h40;
    localparam reg_addr_t KON_BASE  = 8'hB0;
    localparam reg_addr_t CNT_BASE  = 8'hC0;

endpackage

// ==== op_slot_if.sv ====
// slot issue bus
// carries the slot being issued and its register values into the pipeline
`timescale 1ns/1ps

interface op_slot_if;
    import opl3_ctrl_pkg::*;

    logic      valid;
    bank_num_t bank_num;
    op_num_t   op_num;
    mult_t     mult;
    tl_t       tl;
    logic      kon;
    op_out_t   modulation;

    modport sched (output valid, bank_num, op_num);

    modport regs (input bank_num, op_num, output mult, tl, kon);

    modport links (input valid, bank_num, op_num, output modulation);

    modport pipe (input valid, bank_num, op_num, mult, tl, kon, modulation);

endinterface

// ==== op_result_if.sv ====
// pipeline result bus
// one operator output per cycle, tagged with its slot
`timescale 1ns/1ps

interface op_result_if;
    import opl3_ctrl_pkg::*;

    logic      valid;
    bank_num_t bank_num;
    op_num_t   op_num;
    op_out_t   out;

    modport pipe (output valid, bank_num, op_num, out);

    modport links (input valid, bank_num, op_num, out);

endinterface

// ==== reg_bank_mem.sv ====
// two-bank register array
// synchronous write port, asynchronous read port, cleared on reset
`timescale 1ns/1ps

module reg_bank_mem #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH      = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wr_en,
    input  opl3_ctrl_pkg::bank_num_t    wr_bank,
    input  logic [$clog2(DEPTH)-1:0]    wr_addr,
    input  logic [DATA_WIDTH-1:0]       wr_data,
    input  opl3_ctrl_pkg::bank_num_t    rd_bank,
    input  logic [$clog2(DEPTH)-1:0]    rd_addr,
    output logic [DATA_WIDTH-1:0]       rd_data
);
    import opl3_ctrl_pkg::*;

    logic [DATA_WIDTH-1:0] mem [NUM_BANKS][DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            mem <= '{default: '0};
        end else if (wr_en) begin
            mem[wr_bank][wr_addr] <= wr_data;
        end
    end

    // read is combinational, a write shows up the next cycle
    assign rd_data = mem[rd_bank][rd_addr];

endmodule

// ==== operator_regs.sv ====
// operator and channel register file
// decodes writes into mult/tl/kon/cnt memories and looks up the issued slot
`timescale 1ns/1ps

module operator_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      reg_wr_valid,
    input  opl3_ctrl_pkg::bank_num_t  reg_wr_bank,
    input  opl3_ctrl_pkg::reg_addr_t  reg_wr_addr,
    input  opl3_ctrl_pkg::reg_data_t  reg_wr_data,
    input  opl3_ctrl_pkg::conn_sel_t  connection_sel,
    op_slot_if.regs                   slot,
    output logic                      cnt
);
    import opl3_ctrl_pkg::*;

    localparam int OP_AW = $clog2(OP_REG_DEPTH);

    reg_addr_t mult_off;
    reg_addr_t tl_off;
    reg_addr_t kon_off;
    reg_addr_t cnt_off;
    logic      mult_wr;
    logic      tl_wr;
    logic      kon_wr;
    logic      cnt_wr;

    logic [OP_AW-1:0] op_reg_off;
    logic [1:0]       op_mod3;     // position within a group of three
    logic [1:0]       op_group;    // 0: ops 0-5, 1: ops 6-11, 2: ops 12-17
    logic [2:0]       conn_idx;
    chan_num_t        base_chan;
    chan_num_t        kon_chan;

    // write decode
    always_comb begin
        mult_off = reg_wr_addr - MULT_BASE;
        tl_off   = reg_wr_addr - TL_BASE;
        kon_off  = reg_wr_addr - KON_BASE;
        cnt_off  = reg_wr_addr - CNT_BASE;
        mult_wr  = reg_wr_valid && reg_wr_addr >= MULT_BASE && mult_off < OP_REG_DEPTH;
        tl_wr    = reg_wr_valid && reg_wr_addr >= TL_BASE && tl_off < OP_REG_DEPTH;
        kon_wr   = reg_wr_valid && reg_wr_addr >= KON_BASE && kon_off < NUM_CHANNELS;
        cnt_wr   = reg_wr_valid && reg_wr_addr >= CNT_BASE && cnt_off < NUM_CHANNELS;
    end

    // slot to register offset and channel
    always_comb begin
        op_mod3 = 2'(slot.op_num % 3);
        if (slot.op_num < 6) begin
            op_group   = 2'd0;
            op_reg_off = OP_AW'(slot.op_num);
        end else if (slot.op_num < 12) begin
            op_group   = 2'd1;
            op_reg_off = OP_AW'(slot.op_num + 2);
        end else begin
            op_group   = 2'd2;
            op_reg_off = OP_AW'(slot.op_num + 4);
        end
        base_chan = 4'd3 * op_group + op_mod3;
        conn_idx  = 3'(op_mod3) + (slot.bank_num[0] ? 3'd3 : 3'd0);
        // 4-op pair: ops 6-11 follow kon of channel 0-2
        if (op_group == 2'd1 && connection_sel[conn_idx])
            kon_chan = chan_num_t'(op_mod3);
        else
            kon_chan = base_chan;
    end

    reg_bank_mem #(.DATA_WIDTH($bits(mult_t)), .DEPTH(OP_REG_DEPTH)) u_mult_mem (
        .clk, .rst,
        .wr_en(mult_wr), .wr_bank(reg_wr_bank), .wr_addr(mult_off[OP_AW-1:0]),
        .wr_data(reg_wr_data[$bits(mult_t)-1:0]),
        .rd_bank(slot.bank_num), .rd_addr(op_reg_off), .rd_data(slot.mult)
    );

    reg_bank_mem #(.DATA_WIDTH($bits(tl_t)), .DEPTH(OP_REG_DEPTH)) u_tl_mem (
        .clk, .rst,
        .wr_en(tl_wr), .wr_bank(reg_wr_bank), .wr_addr(tl_off[OP_AW-1:0]),
        .wr_data(reg_wr_data[$bits(tl_t)-1:0]),
        .rd_bank(slot.bank_num), .rd_addr(op_reg_off), .rd_data(slot.tl)
    );

    reg_bank_mem #(.DATA_WIDTH(1), .DEPTH(NUM_CHANNELS)) u_kon_mem (
        .clk, .rst,
        .wr_en(kon_wr), .wr_bank(reg_wr_bank), .wr_addr(kon_off[$bits(chan_num_t)-1:0]),
        .wr_data(reg_wr_data[KON_BIT]),
        .rd_bank(slot.bank_num), .rd_addr(kon_chan), .rd_data(slot.kon)
    );

    reg_bank_mem #(.DATA_WIDTH(1), .DEPTH(NUM_CHANNELS)) u_cnt_mem (
        .clk, .rst,
        .wr_en(cnt_wr), .wr_bank(reg_wr_bank), .wr_addr(cnt_off[$bits(chan_num_t)-1:0]),
        .wr_data(reg_wr_data[CNT_BIT]),
        .rd_bank(slot.bank_num), .rd_addr(base_chan), .rd_data(cnt)   // always base channel
    );

endmodule

// ==== slot_scheduler.sv ====
// slot scheduler
// one sweep of all operator slots per sample enable, one slot per cycle
`timescale 1ns/1ps

module slot_scheduler #(
    parameter int NUM_OPS_PER_BANK = opl3_ctrl_pkg::NUM_OPS_PER_BANK
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     sample_clk_en,
    op_slot_if.sched slot
);
    import opl3_ctrl_pkg::*;

    localparam int NUM_SLOTS = NUM_BANKS * NUM_OPS_PER_BANK;
    localparam int CNT_W     = $clog2(NUM_SLOTS);

    sched_state_t     state;
    logic [CNT_W-1:0] slot_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= SCHED_IDLE;
            slot_cnt <= '0;
        end else begin
            case (state)
                SCHED_IDLE: begin
                    slot_cnt <= '0;
                    if (sample_clk_en)
                        state <= SCHED_SWEEP;
                end
                SCHED_SWEEP: begin
                    if (slot_cnt == CNT_W'(NUM_SLOTS - 1))
                        state <= SCHED_IDLE;   // sample_clk_en ignored until here
                    else
                        slot_cnt <= slot_cnt + 1'b1;
                end
                default: state <= SCHED_IDLE;
            endcase
        end
    end

    // bank 0 ops first, then bank 1
    always_comb begin
        slot.valid = state == SCHED_SWEEP;
        if (slot_cnt >= CNT_W'(NUM_OPS_PER_BANK)) begin
            slot.bank_num = bank_num_t'(1);
            slot.op_num   = op_num_t'(slot_cnt - CNT_W'(NUM_OPS_PER_BANK));
        end else begin
            slot.bank_num = bank_num_t'(0);
            slot.op_num   = op_num_t'(slot_cnt);
        end
    end

endmodule

// ==== operator_links.sv ====
// operator links
// output store, modulation routing from op-3, output capture and sweep done
`timescale 1ns/1ps

module operator_links #(
    parameter int NUM_OPS_PER_BANK = opl3_ctrl_pkg::NUM_OPS_PER_BANK,
    parameter int PIPELINE_DELAY   = opl3_ctrl_pkg::PIPELINE_DELAY
) (
    input  logic                      clk,
    input  logic                      rst,
    op_slot_if.links                  slot,
    input  logic                      cnt,
    input  opl3_ctrl_pkg::conn_sel_t  connection_sel,
    op_result_if.links                result,
    output opl3_ctrl_pkg::op_out_t    operator_out [opl3_ctrl_pkg::NUM_BANKS][NUM_OPS_PER_BANK],
    output logic                      ops_done
);
    import opl3_ctrl_pkg::*;

    localparam int DRAIN_W = $clog2(PIPELINE_DELAY + 1);

    op_out_t            out_store [NUM_BANKS][NUM_OPS_PER_BANK];
    op_num_t            src_op;
    logic [2:0]         conn_idx;
    logic               take_mod;
    logic               last_issue;
    logic [DRAIN_W-1:0] drain_cnt;   // cycles until the last slot's result lands

    // modulation from op-3, result of previous sweep
    always_comb begin
        src_op   = (slot.op_num >= 3) ? op_num_t'(slot.op_num - 3) : '0;
        conn_idx = 3'(slot.op_num - 6) + (slot.bank_num[0] ? 3'd3 : 3'd0);
        if (slot.op_num % 6 >= 3)
            take_mod = !cnt;   // second op of a pair
        else if (slot.op_num >= 6 && slot.op_num < 9)
            take_mod = connection_sel[conn_idx] && !cnt;
        else
            take_mod = 1'b0;
        slot.modulation = take_mod ? out_store[slot.bank_num][src_op] : '0;
    end

    // store doubles as the captured output array
    always_ff @(posedge clk) begin
        if (rst) begin
            out_store <= '{default: '0};
        end else if (result.valid) begin
            out_store[result.bank_num][result.op_num] <= result.out;
        end
    end

    assign operator_out = out_store;

    assign last_issue = slot.valid
                     && slot.bank_num == bank_num_t'(NUM_BANKS - 1)
                     && slot.op_num == op_num_t'(NUM_OPS_PER_BANK - 1);

    // done the cycle after the final result, when result valid falls
    always_ff @(posedge clk) begin
        if (rst) begin
            drain_cnt <= '0;
            ops_done  <= 1'b0;
        end else begin
            ops_done <= drain_cnt == DRAIN_W'(1) && result.valid;
            if (last_issue)
                drain_cnt <= DRAIN_W'(PIPELINE_DELAY);
            else if (drain_cnt != '0)
                drain_cnt <= drain_cnt - 1'b1;
        end
    end

endmodule

// ==== op_level_pipe.sv ====
// operator level pipeline
// out = kon ? modulation + (63 - tl) * mult : 0, fixed latency
`timescale 1ns/1ps

module op_level_pipe #(
    parameter int PIPELINE_DELAY = opl3_ctrl_pkg::PIPELINE_DELAY
) (
    input  logic       clk,
    input  logic       rst,
    op_slot_if.pipe    slot,
    op_result_if.pipe  result
);
    import opl3_ctrl_pkg::*;

    localparam int LEVEL_W = $bits(tl_t) + $bits(mult_t);
    localparam int TAIL    = PIPELINE_DELAY - 3;   // stage 4 onwards

    logic [PIPELINE_DELAY-1:0] valid_sr;
    bank_num_t                 bank_sr [PIPELINE_DELAY];
    op_num_t                   op_sr   [PIPELINE_DELAY];

    tl_t                s1_att;
    mult_t              s1_mult;
    op_out_t            s1_mod;
    logic               s1_kon;
    logic [LEVEL_W-1:0] s2_level;
    op_out_t            s2_mod;
    logic               s2_kon;
    op_out_t            s3_sum;
    logic               s3_kon;
    op_out_t            tail [TAIL];

    // slot tags
    always_ff @(posedge clk) begin
        if (rst)
            valid_sr <= '0;
        else
            valid_sr <= {valid_sr[PIPELINE_DELAY-2:0], slot.valid};
    end

    always_ff @(posedge clk) begin
        bank_sr[0] <= slot.bank_num;
        op_sr[0]   <= slot.op_num;
        for (int i = 1; i < PIPELINE_DELAY; i++) begin
            bank_sr[i] <= bank_sr[i-1];
            op_sr[i]   <= op_sr[i-1];
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        s1_att   <= 6'd63 - slot.tl;   // attenuation to level
        s1_mult  <= slot.mult;
        s1_mod   <= slot.modulation;
        s1_kon   <= slot.kon;
        s2_level <= s1_att * s1_mult;
        s2_mod   <= s1_mod;
        s2_kon   <= s1_kon;
        s3_sum   <= s2_mod + op_out_t'(s2_level);
        s3_kon   <= s2_kon;
        tail[0]  <= s3_kon ? s3_sum : '0;   // key off silences
        for (int i = 1; i < TAIL; i++)
            tail[i] <= tail[i-1];
    end

    assign result.valid    = valid_sr[PIPELINE_DELAY-1];
    assign result.bank_num = bank_sr[PIPELINE_DELAY-1];
    assign result.op_num   = op_sr[PIPELINE_DELAY-1];
    assign result.out      = tail[TAIL-1];

endmodule

// ==== operator_ctrl_top.sv ====
// operator control block top level
// time-shares one operator pipeline across 2 banks of 18 slots
`timescale 1ns/1ps

module operator_ctrl_top #(
    parameter int NUM_OPS_PER_BANK = opl3_ctrl_pkg::NUM_OPS_PER_BANK,
    parameter int PIPELINE_DELAY   = opl3_ctrl_pkg::PIPELINE_DELAY
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      sample_clk_en,
    input  logic                      reg_wr_valid,
    input  opl3_ctrl_pkg::bank_num_t  reg_wr_bank,
    input  opl3_ctrl_pkg::reg_addr_t  reg_wr_addr,
    input  opl3_ctrl_pkg::reg_data_t  reg_wr_data,
    input  opl3_ctrl_pkg::conn_sel_t  connection_sel,
    output opl3_ctrl_pkg::op_out_t    operator_out [opl3_ctrl_pkg::NUM_BANKS][NUM_OPS_PER_BANK],
    output logic                      ops_done
);

    logic cnt;   // channel connection of the issued slot

    op_slot_if   slot_bus ();
    op_result_if result_bus ();

    slot_scheduler #(
        .NUM_OPS_PER_BANK(NUM_OPS_PER_BANK)
    ) u_sched (
        .clk,
        .rst,
        .sample_clk_en,
        .slot(slot_bus)
    );

    operator_regs u_regs (
        .clk,
        .rst,
        .reg_wr_valid,
        .reg_wr_bank,
        .reg_wr_addr,
        .reg_wr_data,
        .connection_sel,
        .slot(slot_bus),
        .cnt
    );

    operator_links #(
        .NUM_OPS_PER_BANK(NUM_OPS_PER_BANK),
        .PIPELINE_DELAY(PIPELINE_DELAY)
    ) u_links (
        .clk,
        .rst,
        .slot(slot_bus),
        .cnt,
        .connection_sel,
        .result(result_bus),
        .operator_out,
        .ops_done
    );

    op_level_pipe #(
        .PIPELINE_DELAY(PIPELINE_DELAY)
    ) u_pipe (
        .clk,
        .rst,
        .slot(slot_bus),
        .result(result_bus)
    );

endmodule

// ==== tb_checker.sv ====
// sweep checker
// compares the captured operator outputs with the model and times ops_done
`timescale 1ns/1ps

module tb_checker #(
    parameter int DONE_LATENCY = 43
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    sample_clk_en,
    input  logic                    ops_done,
    input  logic                    check_req,
    input  logic [95:0]             test_name,
    input  opl3_ctrl_pkg::op_out_t  operator_out [opl3_ctrl_pkg::NUM_BANKS]
                                                 [opl3_ctrl_pkg::NUM_OPS_PER_BANK],
    input  opl3_ctrl_pkg::op_out_t  expected [opl3_ctrl_pkg::NUM_BANKS]
                                             [opl3_ctrl_pkg::NUM_OPS_PER_BANK],
    output int                      checks,
    output int                      value_errs,
    output int                      timing_errs
);
    import opl3_ctrl_pkg::*;

    logic busy;       // sweep started and done not yet seen
    int   wait_cyc;

    task automatic compare_outputs();
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int op = 0; op < NUM_OPS_PER_BANK; op++) begin
                checks++;
                if (operator_out[b][op] !== expected[b][op]) begin
                    value_errs++;
                    $display("[FAIL] %0s bank %0d op %0d: expected %0d, actual %0d",
                             test_name, b, op, expected[b][op], operator_out[b][op]);
                end
            end
        end
    endtask

    // sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (rst) begin
            busy        = 1'b0;
            wait_cyc    = 0;
            checks      = 0;
            value_errs  = 0;
            timing_errs = 0;
        end else begin
            if (busy)
                wait_cyc++;
            if (ops_done) begin
                checks++;
                if (!busy) begin
                    timing_errs++;
                    $display("ops_done pulsed while no sweep was running in %0s", test_name);
                end else if (wait_cyc != DONE_LATENCY) begin
                    timing_errs++;
                    $display("[FAIL] %0s ops_done latency: expected %0d, actual %0d",
                             test_name, DONE_LATENCY, wait_cyc);
                end
                busy = 1'b0;   // a second cycle of done counts as stray
            end
            if (sample_clk_en && !busy) begin
                busy     = 1'b1;
                wait_cyc = 0;
            end
            if (check_req)
                compare_outputs();
        end
    end

endmodule

// ==== tb_operator_ctrl.sv ====
// testbench for the operator control block
// table-driven register writes and sweeps checked against a behavioral model
`timescale 1ns/1ps

module tb_operator_ctrl;
    import opl3_ctrl_pkg::*;

    localparam int NUM_ROWS   = 5;
    localparam int NUM_WRITES = 18;
    localparam int RST_CYCLES = 5;

    typedef struct {
        logic [95:0] name;
        int          wr_first;
        int          wr_count;
        conn_sel_t   conn;
        int          sweeps;
    } row_t;

    // run of writes to consecutive addresses
    typedef struct {
        bank_num_t bank;
        reg_addr_t addr;
        int        span;
        reg_data_t data;
        bit        rnd;    // data from the LCG
    } wr_t;

    row_t rows [NUM_ROWS] = '{
        '{"reset_idle", 0, 0, 6'b000000, 1},
        '{"level_map", 0, 8, 6'b000000, 1},
        '{"mod_chain", 8, 2, 6'b000000, 2},
        '{"conn_sel", 10, 2, 6'b101011, 3},
        '{"kon_off", 12, 6, 6'b000000, 2}
    };

    wr_t wr_tab [NUM_WRITES] = '{
        '{0, 8'hB0, 9, 8'h20, 0}, '{1, 8'hB0, 9, 8'h20, 0},   // kon on everywhere
        '{0, 8'hC0, 9, 8'h01, 0}, '{1, 8'hC0, 9, 8'h01, 0},
        '{0, 8'h20, 22, 8'h00, 1}, '{1, 8'h20, 22, 8'h00, 1},  // mult, gaps included
        '{0, 8'h40, 22, 8'h00, 1}, '{1, 8'h40, 22, 8'h00, 1},  // tl
        '{0, 8'hC0, 9, 8'h00, 0}, '{1, 8'hC0, 9, 8'h00, 0},
        '{0, 8'hB3, 1, 8'h00, 0}, '{1, 8'hB4, 1, 8'h00, 0},
        '{1, 8'hB7, 1, 8'h00, 0},
        '{0, 8'h36, 1, 8'hFF, 0}, '{0, 8'h60, 1, 8'hFF, 0},    // unmapped from here
        '{1, 8'hB9, 1, 8'hFF, 0}, '{1, 8'hD0, 1, 8'hFF, 0},
        '{1, 8'hE0, 1, 8'h00, 0}
    };

    logic        clk;
    logic        rst;
    logic        sample_clk_en;
    logic        reg_wr_valid;
    bank_num_t   reg_wr_bank;
    reg_addr_t   reg_wr_addr;
    reg_data_t   reg_wr_data;
    conn_sel_t   connection_sel;
    op_out_t     operator_out [NUM_BANKS][NUM_OPS_PER_BANK];
    logic        ops_done;
    logic        check_req;
    logic [95:0] check_name;
    int          checks;
    int          value_errs;
    int          timing_errs;
    int          cycle_cnt = 0;
    int          cycle_limit = 1000;

    // reference model state
    mult_t       m_mult [NUM_BANKS][NUM_OPS_PER_BANK] = '{default: '0};
    tl_t         m_tl [NUM_BANKS][NUM_OPS_PER_BANK] = '{default: '0};
    bit          m_kon [NUM_BANKS][NUM_CHANNELS];
    bit          m_cnt [NUM_BANKS][NUM_CHANNELS];
    op_out_t     exp_out [NUM_BANKS][NUM_OPS_PER_BANK] = '{default: '0};
    logic [31:0] lcg_state = 32'h3d68_4272;

    operator_ctrl_top u_dut (
        .clk, .rst, .sample_clk_en, .reg_wr_valid, .reg_wr_bank, .reg_wr_addr,
        .reg_wr_data, .connection_sel, .operator_out, .ops_done
    );

    tb_checker u_checker (
        .clk, .rst, .sample_clk_en, .ops_done, .check_req, .test_name(check_name),
        .operator_out, .expected(exp_out), .checks, .value_errs, .timing_errs
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: no ops_done within the limit of %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // operator register offset, groups of six spaced by two
    function automatic int reg_offset(int op);
        if (op < 6)
            return op;
        else if (op < 12)
            return op + 2;
        return op + 4;
    endfunction

    function automatic void model_write(bank_num_t b, reg_addr_t a, reg_data_t d);
        for (int op = 0; op < NUM_OPS_PER_BANK; op++) begin
            if (a == 8'h20 + reg_offset(op))
                m_mult[b][op] = d[3:0];
            if (a == 8'h40 + reg_offset(op))
                m_tl[b][op] = d[5:0];
        end
        if (a >= 8'hB0 && a <= 8'hB8)
            m_kon[b][a - 8'hB0] = d[5];
        if (a >= 8'hC0 && a <= 8'hC8)
            m_cnt[b][a - 8'hC0] = d[0];
    endfunction

    // one sweep; modulation always comes from the previous sweep
    function automatic void model_sweep(conn_sel_t conn);
        op_out_t next [NUM_BANKS][NUM_OPS_PER_BANK];
        int      base;
        int      kon_ch;
        int      level;
        int      modv;
        bit      sel;
        bit      take;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int op = 0; op < NUM_OPS_PER_BANK; op++) begin
                base   = 3 * (op / 6) + op % 3;
                sel    = conn[3 * b + op % 3];
                kon_ch = (op >= 6 && op < 12 && sel) ? op % 3 : base;
                if ((op >= 3 && op < 6) || (op >= 9 && op < 12) || op >= 15)
                    take = !m_cnt[b][base];
                else
                    take = op >= 6 && op < 9 && sel && !m_cnt[b][base];
                modv = 0;
                if (take)
                    modv = int'(exp_out[b][op - 3]);
                level = (63 - m_tl[b][op]) * m_mult[b][op];
                next[b][op] = m_kon[b][kon_ch] ? op_out_t'(modv + level) : '0;
            end
        end
        exp_out = next;
    endfunction

    task automatic write_reg(input bank_num_t bank, input reg_addr_t addr,
                             input reg_data_t data);
        @(posedge clk);
        #1;
        reg_wr_valid = 1'b1;
        reg_wr_bank  = bank;
        reg_wr_addr  = addr;
        reg_wr_data  = data;
        model_write(bank, addr, data);
    endtask

    task automatic apply_writes(input int first, input int count);
        wr_t         w;
        logic [31:0] rnd_word;
        reg_data_t   d;
        for (int i = first; i < first + count; i++) begin
            w = wr_tab[i];
            for (int k = 0; k < w.span; k++) begin
                d = w.data;
                if (w.rnd) begin
                    rnd_word = next_rand();
                    d        = rnd_word[23:16];
                end
                write_reg(w.bank, w.addr + reg_addr_t'(k), d);
            end
        end
        @(posedge clk);
        #1;
        reg_wr_valid = 1'b0;
    endtask

    task automatic run_sweep();
        @(posedge clk);
        #1;
        sample_clk_en = 1'b1;
        @(posedge clk);
        #1;
        sample_clk_en = 1'b0;
        @(negedge clk);
        while (!ops_done)
            @(negedge clk);
    endtask

    task automatic request_check();
        @(posedge clk);
        #1;
        check_req = 1'b1;
        @(posedge clk);
        #1;
        check_req = 1'b0;
    endtask

    initial begin
        rst            = 1'b1;
        sample_clk_en  = 1'b0;
        reg_wr_valid   = 1'b0;
        reg_wr_bank    = '0;
        reg_wr_addr    = '0;
        reg_wr_data    = '0;
        connection_sel = '0;
        check_req      = 1'b0;
        check_name     = "reset";
        cycle_limit    = RST_CYCLES + 10;
        for (int r = 0; r < NUM_ROWS; r++) begin
            cycle_limit += rows[r].sweeps * 60 + 2;
            for (int i = rows[r].wr_first; i < rows[r].wr_first + rows[r].wr_count; i++)
                cycle_limit += wr_tab[i].span;
        end
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge clk);
            #1;
            check_name     = rows[r].name;
            connection_sel = rows[r].conn;
            apply_writes(rows[r].wr_first, rows[r].wr_count);
            for (int s = 0; s < rows[r].sweeps; s++) begin
                run_sweep();
                model_sweep(rows[r].conn);
                request_check();
            end
        end
        repeat (2) @(posedge clk);
        $display("checks %0d, value errors %0d, timing errors %0d",
                 checks, value_errs, timing_errs);
        if (value_errs == 0 && timing_errs == 0 && checks > 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== vlog.f ====
opl3_ctrl_pkg.sv
op_slot_if.sv
op_result_if.sv
reg_bank_mem.sv
operator_regs.sv
slot_scheduler.sv
operator_links.sv
op_level_pipe.sv
operator_ctrl_top.sv
tb_checker.sv
tb_operator_ctrl.sv

// ==== Makefile ====
# Verilator build and run of the operator control testbench

TOP := tb_operator_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlog.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
